// File: files.f
+incdir+include
src/sinh_pkg.sv
src/sinh_series_core.sv
src/sinh_vector_sequencer.sv
src/sinh_result_fifo.sv
src/sinh_result_drain.sv
src/sinh_vector_unit.sv
test/sinh_vector_unit_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= sinh_vector_unit_tb
RTL_TOP    ?= sinh_vector_unit
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/sinh_macros.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/sinh_vector_unit_tb.sv
`include "sinh_macros.svh"

module sinh_vector_unit_tb
  import sinh_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  // About 30 elements at 20 cycles each plus wide margin
  localparam int TIMEOUT_CYCLES = 4000;

  ////////////////////
  // DUT signals
  ////////////////////

  logic                     CLK;
  logic                     RST;
  logic                     start;
  logic [`SINH_INDEX_W-1:0] size_in;
  logic [`SINH_DATA_W-1:0]  modulo_in;
  logic                     ready;
  logic [`SINH_DATA_W-1:0]  data_in;
  logic                     data_in_enable;
  logic                     elem_done;
  logic                     pop;
  logic [`SINH_DATA_W-1:0]  result_data;
  logic                     result_strobe;
  logic                     result_last;
  logic                     result_avail;

  // Scoreboard state
  sinh_entry_t exp_q[$];
  logic        pending_q[$];
  sinh_entry_t want;
  sinh_entry_t seen;
  logic        pend_last;
  int          cycles = 0;
  int          errors = 0;
  int          err_at_start;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          sent_cnt = 0;
  int          done_cnt = 0;
  int          ready_cnt = 0;
  int          strobe_cnt = 0;
  int          enable_cycle;
  int          done_cycle;
  int          ready_cycle;
  int          seed;

  sinh_vector_unit dut0 (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .size_in        (size_in),
    .modulo_in      (modulo_in),
    .ready          (ready),
    .data_in        (data_in),
    .data_in_enable (data_in_enable),
    .elem_done      (elem_done),
    .pop            (pop),
    .result_data    (result_data),
    .result_strobe  (result_strobe),
    .result_last    (result_last),
    .result_avail   (result_avail)
  );

  // 100 ns clock
  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  // Cycle count and run limit
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////
  // Reference model
  ////////////////////

  // Four-term series x + x^3/3! + x^5/5! + x^7/7! in Q4.12
  function automatic logic [`SINH_DATA_W-1:0] sinh_model(input logic [`SINH_DATA_W-1:0] x,
                                                         input logic [`SINH_DATA_W-1:0] m);
    logic [63:0]            term;
    logic [63:0]            x64;
    logic [63:0]            prod;
    logic [63:0]            shifted;
    logic [`SINH_ACC_W-1:0] scaled;
    logic [`SINH_ACC_W-1:0] div;
    logic [`SINH_ACC_W-1:0] sum;
    logic [`SINH_ACC_W-1:0] rem;
    int                     k;
    x64  = {48'b0, x};
    term = x64;
    sum  = {{(`SINH_ACC_W - `SINH_DATA_W){1'b0}}, x};
    for (k = 0; k < 3; k++) begin
      prod    = term * x64 * x64;
      shifted = prod >> (2 * `SINH_FRAC_W);
      scaled  = shifted[`SINH_ACC_W-1:0];
      // Odd factorial ratios
      div     = (k == 0) ? 6 : (k == 1) ? 20 : 42;
      term    = {32'b0, scaled / div};
      sum     = sum + term[`SINH_ACC_W-1:0];
    end
    if (m != '0) begin
      rem = sum % {{(`SINH_ACC_W - `SINH_DATA_W){1'b0}}, m};
      return rem[`SINH_DATA_W-1:0];
    end else begin
      return sum[`SINH_DATA_W-1:0];
    end
  endfunction

  ////////////////////
  // Output monitor
  ////////////////////

  // Sampled mid-cycle where all outputs have settled
  always @(negedge CLK) begin
    if (!RST) begin
      if (elem_done) begin
        done_cnt++;
        done_cycle = cycles;
        if (pending_q.size() == 0) begin
          $display("Unexpected elem_done with no element outstanding at cycle %0d", cycles);
          errors++;
        end else begin
          pend_last = pending_q.pop_front();
          // Ready only on the final element
          if (ready !== pend_last) begin
            $display("Error: ready got %h expected %h", ready, pend_last);
            errors++;
          end
        end
      end else if (ready) begin
        $display("ready pulsed without elem_done at cycle %0d", cycles);
        errors++;
      end
      if (ready) begin
        ready_cnt++;
        ready_cycle = cycles;
      end
      if (result_strobe) begin
        strobe_cnt++;
        if (exp_q.size() == 0) begin
          $display("result_strobe with no result outstanding at cycle %0d", cycles);
          errors++;
        end else begin
          seen = exp_q.pop_front();
          if (result_data !== seen.value) begin
            $display("Error: result_data got %h expected %h", result_data, seen.value);
            errors++;
          end
          if (result_last !== seen.last) begin
            $display("Error: result_last got %h expected %h", result_last, seen.last);
            errors++;
          end
        end
      end else if (result_last) begin
        $display("result_last pulsed without result_strobe at cycle %0d", cycles);
        errors++;
      end
    end
  end

  ////////////////////
  // Driver tasks
  ////////////////////

  // Drive point 1 ns after the edge
  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic start_vector(input int size, input logic [`SINH_DATA_W-1:0] modulus);
    start     = 1'b1;
    size_in   = size[`SINH_INDEX_W-1:0];
    modulo_in = modulus;
    next_cycle();
    start     = 1'b0;
  endtask

  // One data_in_enable strobe with its expected result queued
  task automatic send_element(input logic [`SINH_DATA_W-1:0] x,
                              input logic [`SINH_DATA_W-1:0] modulus, input logic is_last);
    data_in        = x;
    data_in_enable = 1'b1;
    enable_cycle   = cycles;
    pending_q.push_back(is_last);
    want.value     = sinh_model(x, modulus);
    want.last      = is_last;
    exp_q.push_back(want);
    sent_cnt++;
    next_cycle();
    data_in_enable = 1'b0;
  endtask

  task automatic wait_all_done();
    while (done_cnt < sent_cnt) next_cycle();
  endtask

  // Pop the head and wait for its strobe
  task automatic pop_one();
    int target;
    target = strobe_cnt + 1;
    while (!result_avail) next_cycle();
    pop = 1'b1;
    next_cycle();
    pop = 1'b0;
    while (strobe_cnt < target) next_cycle();
  endtask

  task automatic begin_test();
    err_at_start = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == err_at_start) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - err_at_start);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic single_element_test();
    begin_test();
    start_vector(1, 16'h0000);
    // 1.5 in Q4.12
    send_element(16'h1800, 16'h0000, 1'b1);
    wait_all_done();
    if (done_cycle - enable_cycle != 7) begin
      $display("Error: elem_done latency got %h expected %h", done_cycle - enable_cycle, 7);
      errors++;
    end
    if (ready_cycle != done_cycle) begin
      $display("Error: ready cycle got %h expected %h", ready_cycle, done_cycle);
      errors++;
    end
    pop_one();
    end_test("single_element");
  endtask

  task automatic modular_test();
    logic [`SINH_DATA_W-1:0] m;
    logic [`SINH_DATA_W-1:0] x;
    int                      rnd;
    int                      i;
    begin_test();
    m = 16'h2f1b;
    start_vector(8, m);
    for (i = 0; i < 8; i++) begin
      rnd = $random(seed);
      x   = rnd[`SINH_DATA_W-1:0];
      // Corner inputs at both ends
      if (i == 0) x = '0;
      if (i == 7) x = '1;
      send_element(x, m, i == 7);
      wait_all_done();
      pop_one();
    end
    end_test("modular_reduction");
  endtask

  task automatic backpressure_test();
    logic [`SINH_DATA_W-1:0] xs [7];
    int                      rnd;
    int                      i;
    begin_test();
    for (i = 0; i < 7; i++) begin
      rnd   = $random(seed);
      xs[i] = rnd[`SINH_DATA_W-1:0];
    end
    start_vector(7, 16'h0000);
    // Fill the FIFO
    for (i = 0; i < `SINH_FIFO_DEPTH; i++) begin
      send_element(xs[i], 16'h0000, 1'b0);
      wait_all_done();
    end
    // Fifth element stalls on full
    send_element(xs[4], 16'h0000, 1'b0);
    repeat (12) next_cycle();
    if (done_cnt != sent_cnt - 1) begin
      $display("Error: elem_done count got %h expected %h", done_cnt, sent_cnt - 1);
      errors++;
    end
    if (result_avail !== 1'b1) begin
      $display("Error: result_avail got %h expected %h", result_avail, 1'b1);
      errors++;
    end
    // Each pop frees one slot for the stalled write
    for (i = 4; i < 7; i++) begin
      pop_one();
      wait_all_done();
      if (i < 6) send_element(xs[i + 1], 16'h0000, i + 1 == 6);
    end
    while (strobe_cnt < sent_cnt) pop_one();
    end_test("fifo_backpressure");
  endtask

  task automatic ignored_strobe_test();
    int base_done;
    int base_strobe;
    begin_test();
    if (result_avail !== 1'b0) begin
      $display("Error: result_avail got %h expected %h", result_avail, 1'b0);
      errors++;
    end
    base_done      = done_cnt;
    base_strobe    = strobe_cnt;
    // Enable in idle and pop with nothing available
    data_in        = 16'h1234;
    data_in_enable = 1'b1;
    pop            = 1'b1;
    repeat (3) next_cycle();
    data_in_enable = 1'b0;
    pop            = 1'b0;
    repeat (10) next_cycle();
    if (done_cnt != base_done) begin
      $display("Error: elem_done count got %h expected %h", done_cnt, base_done);
      errors++;
    end
    if (strobe_cnt != base_strobe) begin
      $display("Error: result_strobe count got %h expected %h", strobe_cnt, base_strobe);
      errors++;
    end
    // Next vector runs normally
    start_vector(2, 16'h0101);
    send_element(16'h0c00, 16'h0101, 1'b0);
    wait_all_done();
    // Entry already in the FIFO but result_avail still low
    if (result_avail !== 1'b0) begin
      $display("Error: result_avail got %h expected %h", result_avail, 1'b0);
      errors++;
    end
    base_strobe = strobe_cnt;
    pop         = 1'b1;
    next_cycle();
    pop         = 1'b0;
    repeat (3) next_cycle();
    if (strobe_cnt != base_strobe) begin
      $display("Error: result_strobe count got %h expected %h", strobe_cnt, base_strobe);
      errors++;
    end
    send_element(16'h2345, 16'h0101, 1'b1);
    wait_all_done();
    pop_one();
    pop_one();
    end_test("ignored_strobes");
  endtask

  task automatic back_to_back_test();
    int                      sizes [3];
    logic [`SINH_DATA_W-1:0] mods [3];
    logic [`SINH_DATA_W-1:0] x;
    int                      rnd;
    int                      ready_base;
    int                      v;
    int                      i;
    begin_test();
    sizes = '{1, 5, 3};
    mods  = '{16'h0000, 16'h7ff1, 16'h0000};
    for (v = 0; v < 3; v++) begin
      ready_base = ready_cnt;
      start_vector(sizes[v], mods[v]);
      for (i = 0; i < sizes[v]; i++) begin
        rnd = $random(seed);
        x   = rnd[`SINH_DATA_W-1:0];
        send_element(x, mods[v], i == sizes[v] - 1);
        wait_all_done();
        // Random pops that are forced once the FIFO is full
        rnd = $random(seed);
        if (rnd[0] || (sent_cnt - strobe_cnt >= `SINH_FIFO_DEPTH)) pop_one();
      end
      if (ready_cnt != ready_base + 1) begin
        $display("Error: ready count got %h expected %h", ready_cnt, ready_base + 1);
        errors++;
      end
    end
    while (strobe_cnt < sent_cnt) pop_one();
    end_test("back_to_back");
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    seed           = 32'h1b5e;
    RST            = 1'b1;
    start          = 1'b0;
    size_in        = '0;
    modulo_in      = '0;
    data_in        = '0;
    data_in_enable = 1'b0;
    pop            = 1'b0;
    repeat (10) @(posedge CLK);
    #1;
    RST = 1'b0;
    next_cycle();
    single_element_test();
    modular_test();
    backpressure_test();
    ignored_strobe_test();
    back_to_back_test();
    repeat (5) next_cycle();
    if (exp_q.size() != 0) begin
      $display("%0d expected results never reached the host", exp_q.size());
      errors++;
    end
    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: src/sinh_vector_unit.sv
`include "sinh_macros.svh"

module sinh_vector_unit
  import sinh_pkg::*;
(
  input  logic                     CLK,
  input  logic                     RST,

  // Vector control
  input  logic                     start,
  input  logic [`SINH_INDEX_W-1:0] size_in,
  input  logic [`SINH_DATA_W-1:0]  modulo_in,
  output logic                     ready,

  // Element input
  input  logic [`SINH_DATA_W-1:0]  data_in,
  input  logic                     data_in_enable,
  output logic                     elem_done,

  // Result output
  input  logic                     pop,
  output logic [`SINH_DATA_W-1:0]  result_data,
  output logic                     result_strobe,
  output logic                     result_last,
  output logic                     result_avail
);

  ////////////////////
  // Internal wires
  ////////////////////

  // Sequencer to FIFO
  logic        fifo_write;
  sinh_entry_t write_entry;
  logic        fifo_full;

  // FIFO to drain
  logic        fifo_read;
  sinh_entry_t head_entry;
  logic        fifo_empty;

  ////////////////////
  // Producer
  ////////////////////

  sinh_vector_sequencer seq0 (
    .CLK            (CLK),
    .RST            (RST),
    .start          (start),
    .size_in        (size_in),
    .modulo_in      (modulo_in),
    .data_in_enable (data_in_enable),
    .data_in        (data_in),
    .fifo_full      (fifo_full),
    .ready          (ready),
    .elem_done      (elem_done),
    .fifo_write     (fifo_write),
    .fifo_entry     (write_entry)
  );

  // Result buffer
  sinh_result_fifo fifo0 (
    .CLK         (CLK),
    .RST         (RST),
    .write       (fifo_write),
    .write_entry (write_entry),
    .read        (fifo_read),
    .read_entry  (head_entry),
    .full        (fifo_full),
    .empty       (fifo_empty)
  );

  ////////////////////
  // Consumer
  ////////////////////

  sinh_result_drain drain0 (
    .CLK           (CLK),
    .RST           (RST),
    .pop           (pop),
    .fifo_empty    (fifo_empty),
    .head_entry    (head_entry),
    .fifo_read     (fifo_read),
    .result_data   (result_data),
    .result_strobe (result_strobe),
    .result_last   (result_last),
    .result_avail  (result_avail)
  );

endmodule

// File: src/sinh_result_drain.sv
`include "sinh_macros.svh"

module sinh_result_drain
  import sinh_pkg::*;
(
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    pop,
  input  logic                    fifo_empty,
  input  sinh_entry_t             head_entry,
  output logic                    fifo_read,
  output logic [`SINH_DATA_W-1:0] result_data,
  output logic                    result_strobe,
  output logic                    result_last,
  output logic                    result_avail
);

  ////////////////////
  // Pop qualification
  ////////////////////

  // Pop honored only with data shown to the host
  // Empty check covers the cycle where result_avail still lags
  assign fifo_read = pop && result_avail && !fifo_empty;

  ////////////////////
  // Host side flags
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      result_avail  <= 1'b0;
      result_strobe <= 1'b0;
      result_last   <= 1'b0;
    end else begin
      // Registered copy of not empty
      result_avail  <= !fifo_empty;
      // Strobe one cycle after the read
      result_strobe <= fifo_read;
      // Vector boundary marker
      result_last   <= fifo_read && head_entry.last;
    end
  end

  ////////////////////
  // Result value
  ////////////////////

  always_ff @(posedge CLK) begin
    if (fifo_read) begin
      result_data <= head_entry.value;
    end
  end

endmodule

// File: src/sinh_result_fifo.sv
`include "sinh_macros.svh"

module sinh_result_fifo
  import sinh_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  logic        write,
  input  sinh_entry_t write_entry,
  input  logic        read,
  output sinh_entry_t read_entry,
  output logic        full,
  output logic        empty
);

  ////////////////////
  // Signals
  ////////////////////

  // Storage
  sinh_entry_t                              mem [`SINH_FIFO_DEPTH];

  // Pointers and occupancy
  logic [$clog2(`SINH_FIFO_DEPTH)-1:0]      wr_ptr_q;
  logic [$clog2(`SINH_FIFO_DEPTH)-1:0]      rd_ptr_q;
  logic [$clog2(`SINH_FIFO_DEPTH + 1)-1:0]  count_q;
  logic [$clog2(`SINH_FIFO_DEPTH + 1)-1:0]  count_next;

  // Write while full and read while empty are dropped
  logic                                     do_write;
  logic                                     do_read;

  assign do_write = write && !full;
  assign do_read  = read && !empty;

  // Head entry
  assign read_entry = mem[rd_ptr_q];

  always_comb begin
    count_next = count_q;
    if (do_write && !do_read) begin
      count_next = count_q + 1'b1;
    end else if (do_read && !do_write) begin
      count_next = count_q - 1'b1;
    end
  end

  ////////////////////
  // Pointers and levels
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full     <= 1'b0;
      empty    <= 1'b1;
    end else begin
      if (do_write) begin
        // Wrap at depth
        wr_ptr_q <= (wr_ptr_q == `SINH_FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_read) begin
        rd_ptr_q <= (rd_ptr_q == `SINH_FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_next;
      full    <= (count_next == `SINH_FIFO_DEPTH);
      empty   <= (count_next == '0);
    end
  end

  // Entry storage
  always_ff @(posedge CLK) begin
    if (do_write) begin
      mem[wr_ptr_q] <= write_entry;
    end
  end

endmodule

// File: src/sinh_vector_sequencer.sv
`include "sinh_macros.svh"

module sinh_vector_sequencer
  import sinh_pkg::*;
(
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     start,
  input  logic [`SINH_INDEX_W-1:0] size_in,
  input  logic [`SINH_DATA_W-1:0]  modulo_in,
  input  logic                     data_in_enable,
  input  logic [`SINH_DATA_W-1:0]  data_in,
  input  logic                     fifo_full,
  output logic                     ready,
  output logic                     elem_done,
  output logic                     fifo_write,
  output sinh_entry_t              fifo_entry
);

  ////////////////////
  // Types
  ////////////////////

  typedef enum logic [1:0] {
    STARTER_STATE,
    INPUT_STATE,
    ENDER_STATE
  } seq_state_t;

  ////////////////////
  // Signals
  ////////////////////

  // FSM
  seq_state_t               state_q;
  logic [`SINH_INDEX_W-1:0] index_q;

  // Vector configuration
  sinh_cfg_t                cfg_q;

  // Core handshake
  logic                     core_start_q;
  logic                     core_ready;
  logic [`SINH_DATA_W-1:0]  core_data;
  logic [`SINH_DATA_W-1:0]  elem_q;

  // Result waiting for FIFO space
  logic [`SINH_DATA_W-1:0]  result_q;
  logic                     held_q;

  logic                     is_last;
  logic                     write_now;

  ////////////////////
  // Outputs
  ////////////////////

  // Size zero behaves like size one
  assign is_last   = (cfg_q.count == '0) || (index_q == cfg_q.count - 1'b1);
  // Write as soon as the FIFO has room
  assign write_now = (state_q == ENDER_STATE) && held_q && !fifo_full;

  assign fifo_write = write_now;
  assign elem_done  = write_now;
  assign ready      = write_now && is_last;

  always_comb begin
    fifo_entry.value = result_q;
    fifo_entry.last  = is_last;
  end

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q      <= STARTER_STATE;
      index_q      <= '0;
      core_start_q <= 1'b0;
      held_q       <= 1'b0;
    end else begin
      core_start_q <= 1'b0;
      case (state_q)
        STARTER_STATE: begin
          if (start) begin
            index_q <= '0;
            state_q <= INPUT_STATE;
          end
        end
        INPUT_STATE: begin
          // Element latched here and the core starts next cycle
          if (data_in_enable) begin
            core_start_q <= 1'b1;
            held_q       <= 1'b0;
            state_q      <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          if (core_ready) begin
            held_q <= 1'b1;
          end
          if (write_now) begin
            held_q <= 1'b0;
            if (is_last) begin
              state_q <= STARTER_STATE;
            end else begin
              index_q <= index_q + 1'b1;
              state_q <= INPUT_STATE;
            end
          end
        end
        default: begin
          state_q <= STARTER_STATE;
        end
      endcase
    end
  end

  // Configuration, element and result
  always_ff @(posedge CLK) begin
    if ((state_q == STARTER_STATE) && start) begin
      cfg_q.modulus <= modulo_in;
      cfg_q.count   <= size_in;
    end
    if ((state_q == INPUT_STATE) && data_in_enable) begin
      elem_q <= data_in;
    end
    if (core_ready) begin
      result_q <= core_data;
    end
  end

  ////////////////////
  // Scalar core
  ////////////////////

  sinh_series_core core0 (
    .CLK      (CLK),
    .RST      (RST),
    .start    (core_start_q),
    .modulo   (cfg_q.modulus),
    .data_in  (elem_q),
    .ready    (core_ready),
    .data_out (core_data)
  );

endmodule

// File: src/sinh_series_core.sv
`include "sinh_macros.svh"

module sinh_series_core (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  input  logic [`SINH_DATA_W-1:0] modulo,
  input  logic [`SINH_DATA_W-1:0] data_in,
  output logic                    ready,
  output logic [`SINH_DATA_W-1:0] data_out
);

  ////////////////////
  // Signals
  ////////////////////

  // Sequencing
  logic                                  busy_q;
  logic [$clog2(`SINH_TERMS + 1)-1:0]    step_q;
  logic                                  load;
  logic                                  term_step;
  logic                                  reduce_step;

  // Operands
  logic [`SINH_DATA_W-1:0]               x_q;
  logic [`SINH_DATA_W-1:0]               mod_q;

  // Running term and partial sum
  logic [`SINH_ACC_W-1:0]                term_q;
  logic [`SINH_ACC_W-1:0]                sum_q;

  // Term datapath
  logic [63:0]                           term_ext;
  logic [63:0]                           x_ext;
  logic [63:0]                           product;
  logic [`SINH_ACC_W-1:0]                scaled;
  logic [`SINH_ACC_W-1:0]                divisor;
  logic [`SINH_ACC_W-1:0]                next_term;
  logic [`SINH_ACC_W-1:0]                reduced;

  ////////////////////
  // Step decode
  ////////////////////

  // Start while busy is dropped
  assign load        = start && !busy_q;
  assign reduce_step = busy_q && (step_q == `SINH_TERMS);
  assign term_step   = busy_q && !reduce_step;

  ////////////////////
  // Term datapath
  ////////////////////

  always_comb begin
    term_ext = {{(64 - `SINH_ACC_W){1'b0}}, term_q};
    x_ext    = {{(64 - `SINH_DATA_W){1'b0}}, x_q};
    // term * x * x in 64 bits
    product  = term_ext * x_ext * x_ext;
    // Back to Q4.12 after two multiplies
    scaled   = product[`SINH_ACC_W + 2*`SINH_FRAC_W - 1 : 2*`SINH_FRAC_W];
    // Ratio of consecutive odd factorials
    case (step_q)
      1:       divisor = 6;
      2:       divisor = 20;
      3:       divisor = 42;
      default: divisor = 1;
    endcase
    next_term = scaled / divisor;
    // Modular reduction of the final sum
    reduced   = sum_q % {{(`SINH_ACC_W - `SINH_DATA_W){1'b0}}, mod_q};
  end

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q <= 1'b0;
      step_q <= '0;
      ready  <= 1'b0;
    end else begin
      // One-cycle pulse
      ready <= 1'b0;
      if (load) begin
        busy_q <= 1'b1;
        step_q <= 1;
      end else if (reduce_step) begin
        // Done after load, three terms and reduce
        busy_q <= 1'b0;
        step_q <= '0;
        ready  <= 1'b1;
      end else if (term_step) begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  ////////////////////
  // Datapath registers
  ////////////////////

  always_ff @(posedge CLK) begin
    if (load) begin
      x_q    <= data_in;
      mod_q  <= modulo;
      // First term is x itself
      term_q <= {{(`SINH_ACC_W - `SINH_DATA_W){1'b0}}, data_in};
      sum_q  <= {{(`SINH_ACC_W - `SINH_DATA_W){1'b0}}, data_in};
    end else if (term_step) begin
      term_q <= next_term;
      // Wraps modulo 2^ACC_W
      sum_q  <= sum_q + next_term;
    end
    if (reduce_step) begin
      if (mod_q != '0) begin
        data_out <= reduced[`SINH_DATA_W-1:0];
      end else begin
        data_out <= sum_q[`SINH_DATA_W-1:0];
      end
    end
  end

endmodule

// File: src/sinh_pkg.sv
`include "sinh_macros.svh"

package sinh_pkg;

  ////////////////////
  // Vector configuration
  ////////////////////

  // Latched on start
  typedef struct packed {
    logic [`SINH_DATA_W-1:0]  modulus;  // Zero selects plain truncation
    logic [`SINH_INDEX_W-1:0] count;    // Zero counts as one element
  } sinh_cfg_t;

  ////////////////////
  // Result FIFO entry
  ////////////////////

  typedef struct packed {
    logic [`SINH_DATA_W-1:0] value;
    logic                    last;      // Final element of the vector
  } sinh_entry_t;

endpackage

// File: include/sinh_macros.svh
`ifndef SINH_MACROS_SVH
`define SINH_MACROS_SVH

// Element width in bits
`define SINH_DATA_W 16

// Fraction bits of the unsigned Q4.12 format
`define SINH_FRAC_W 12

// Series accumulator width
`define SINH_ACC_W 32

// Series terms x, x^3/3!, x^5/5! and x^7/7!
`define SINH_TERMS 4

// Element counter and vector size width
`define SINH_INDEX_W 8

// Result FIFO entries
`define SINH_FIFO_DEPTH 4

`endif
